//--- flist.f
src/isaPkg.sv
src/ctrlPkg.sv
src/control.sv
src/immGen.sv
src/regFile.sv
src/alu.sv
src/pcUnit.sv
src/cpuCore.sv
verif/tbCpuCore.sv

//--- src/alu.sv
`timescale 1ns/100ps

module alu import isaPkg::*; import ctrlPkg::*; (
  input  aluFnE      i_fn,
  input  wordT       i_a,
  input  wordT       i_b,
  input  logic [1:0] i_sv,
  output wordT       o_result,
  output logic       o_equal
);

  logic [4:0]  shAmt;
  logic [63:0] rotWide;

  assign shAmt   = i_b[4:0];
  assign rotWide = {i_a, i_a} >> shAmt;   // low half is the rotated word

  always_comb begin
    case (i_fn)
      ALU_ADD:      o_result = i_a + i_b;
      ALU_SUB:      o_result = i_a - i_b;
      ALU_AND:      o_result = i_a & i_b;
      ALU_OR:       o_result = i_a | i_b;
      ALU_XOR:      o_result = i_a ^ i_b;
      ALU_SLL:      o_result = i_a << shAmt;
      ALU_SRL:      o_result = i_a >> shAmt;
      ALU_ROTR:     o_result = rotWide[31:0];
      ALU_PASSB:    o_result = i_b;
      ALU_SCALEADD: o_result = i_a + (i_b << i_sv);   // scaled index address
      default:      o_result = '0;   // cmpeq has no data result
    endcase
  end

  // only meaningful for beq
  assign o_equal = (i_fn == ALU_CMPEQ) && (i_a == i_b);

endmodule

//--- src/control.sv
`timescale 1ns/100ps

module control import isaPkg::*; import ctrlPkg::*; (
  input  opcodeE i_opcode,
  input  subOpE  i_subOpcode,
  output ctrlT   o_ctrl,
  output immSelE o_immSel
);

  // bundle for anything that writes rt
  function automatic ctrlT writeRt(aluFnE fn, logic useImm);
    ctrlT c;
    c          = '0;
    c.regDst   = 1'b1;
    c.regWrite = 1'b1;
    c.aluSrc   = useImm;
    c.aluFn    = fn;
    return c;
  endfunction

  always_comb begin
    o_ctrl   = '0;    // undefined encodings fall through as a nop
    o_immSel = IMM0;
    case (i_opcode)
      OP_ALU: begin
        case (i_subOpcode)
          SUB_ADD: o_ctrl = writeRt(ALU_ADD, 1'b0);
          SUB_SUB: o_ctrl = writeRt(ALU_SUB, 1'b0);
          SUB_AND: o_ctrl = writeRt(ALU_AND, 1'b0);
          SUB_OR:  o_ctrl = writeRt(ALU_OR, 1'b0);
          SUB_XOR: o_ctrl = writeRt(ALU_XOR, 1'b0);
          SUB_SLLI: begin
            o_ctrl   = writeRt(ALU_SLL, 1'b1);
            o_immSel = IMM5;
          end
          SUB_SRLI: begin
            o_ctrl   = writeRt(ALU_SRL, 1'b1);
            o_immSel = IMM5;
          end
          SUB_ROTRI: begin
            o_ctrl   = writeRt(ALU_ROTR, 1'b1);
            o_immSel = IMM5;
          end
          default: ;
        endcase
      end
      OP_ADDI: begin
        o_ctrl   = writeRt(ALU_ADD, 1'b1);
        o_immSel = IMM15;
      end
      OP_ORI: begin
        o_ctrl   = writeRt(ALU_OR, 1'b1);
        o_immSel = IMM15ZE;
      end
      OP_XORI: begin
        o_ctrl   = writeRt(ALU_XOR, 1'b1);
        o_immSel = IMM15ZE;
      end
      OP_MOVI: begin
        o_ctrl   = writeRt(ALU_PASSB, 1'b1);
        o_immSel = IMM20;
      end
      OP_LWI: begin
        o_ctrl          = writeRt(ALU_ADD, 1'b1);
        o_ctrl.memRead  = 1'b1;
        o_ctrl.memToReg = 1'b1;
        o_immSel        = IMM15;
      end
      OP_SWI: begin
        o_ctrl.memWrite = 1'b1;
        o_ctrl.aluSrc   = 1'b1;
        o_ctrl.aluFn    = ALU_ADD;
        o_immSel        = IMM15;
      end
      OP_MEM: begin
        case (i_subOpcode)
          SUB_LW: begin
            o_ctrl          = writeRt(ALU_SCALEADD, 1'b0);
            o_ctrl.memRead  = 1'b1;
            o_ctrl.memToReg = 1'b1;
          end
          SUB_SW: begin
            o_ctrl.memWrite = 1'b1;
            o_ctrl.aluFn    = ALU_SCALEADD;
          end
          default: ;
        endcase
      end
      OP_BEQ: begin
        o_ctrl.branch = 1'b1;   // compares ra with rt
        o_ctrl.aluFn  = ALU_CMPEQ;
        o_immSel      = IMM14;
      end
      OP_J: begin
        o_ctrl.jump = 1'b1;
        o_immSel    = IMM24;
      end
      default: ;
    endcase
  end

endmodule

//--- src/cpuCore.sv
`timescale 1ns/100ps

module cpuCore import isaPkg::*; import ctrlPkg::*; #(
  parameter wordT RESET_PC = 32'h0000_0000
) (
  input  logic   i_clk,
  input  logic   i_rstN,
  input  wordT   i_instr,
  input  wordT   i_memRdata,
  output wordT   o_pc,
  output memReqT o_memReq
);

  regAddrT    rt;
  regAddrT    ra;
  regAddrT    rb;
  logic [1:0] sv;
  ctrlT       ctrl;
  immSelE     immSel;
  wordT       imm;
  wordT       rdataA;
  wordT       rdataB;
  wordT       rdataT;
  wordT       opB;
  wordT       aluResult;
  logic       equal;
  wordT       wbData;
  regAddrT    waddr;

  assign rt = i_instr[RT_HI:RT_LO];
  assign ra = i_instr[RA_HI:RA_LO];
  assign rb = i_instr[RB_HI:RB_LO];
  assign sv = i_instr[SV_HI:SV_LO];

  control uControl (
    .i_opcode   (opcodeE'(i_instr[OPC_HI:OPC_LO])),
    .i_subOpcode(subOpE'(i_instr[SUB_HI:SUB_LO])),
    .o_ctrl     (ctrl),
    .o_immSel   (immSel)
  );

  immGen uImmGen (
    .i_instr (i_instr),
    .i_immSel(immSel),
    .o_imm   (imm)
  );

  assign waddr  = ctrl.regDst ? rt : ra;   // every current writer targets rt
  assign wbData = ctrl.memToReg ? i_memRdata : aluResult;

  // two identical banks give the third read port sw needs (ra, rb, rt)
  regFile uRegsAB (
    .i_clk   (i_clk),
    .i_rstN  (i_rstN),
    .i_raddrA(ra),
    .i_raddrB(rb),
    .i_waddr (waddr),
    .i_we    (ctrl.regWrite),
    .i_wdata (wbData),
    .o_rdataA(rdataA),
    .o_rdataB(rdataB)
  );

  regFile uRegsT (
    .i_clk   (i_clk),
    .i_rstN  (i_rstN),
    .i_raddrA(rt),
    .i_raddrB(rb),
    .i_waddr (waddr),
    .i_we    (ctrl.regWrite),
    .i_wdata (wbData),
    .o_rdataA(rdataT),      // store data and beq operand
    .o_rdataB()
  );

  always_comb begin
    if (ctrl.aluSrc) begin
      opB = imm;
    end else if (ctrl.branch) begin
      opB = rdataT;   // beq compares ra with rt
    end else begin
      opB = rdataB;
    end
  end

  alu uAlu (
    .i_fn    (ctrl.aluFn),
    .i_a     (rdataA),
    .i_b     (opB),
    .i_sv    (sv),
    .o_result(aluResult),
    .o_equal (equal)
  );

  pcUnit #(
    .RESET_PC(RESET_PC)
  ) uPcUnit (
    .i_clk   (i_clk),
    .i_rstN  (i_rstN),
    .i_branch(ctrl.branch),
    .i_jump  (ctrl.jump),
    .i_equal (equal),
    .i_imm   (imm),
    .o_pc    (o_pc)
  );

  assign o_memReq.re    = ctrl.memRead;
  assign o_memReq.we    = ctrl.memWrite;
  assign o_memReq.addr  = aluResult;
  assign o_memReq.wdata = rdataT;

endmodule

//--- src/ctrlPkg.sv
package ctrlPkg;

  import isaPkg::*;

  typedef enum logic [3:0] {
    ALU_ADD      = 4'd0,
    ALU_SUB      = 4'd1,
    ALU_AND      = 4'd2,
    ALU_OR       = 4'd3,
    ALU_XOR      = 4'd4,
    ALU_SLL      = 4'd5,
    ALU_SRL      = 4'd6,
    ALU_ROTR     = 4'd7,
    ALU_PASSB    = 4'd8,   // movi
    ALU_SCALEADD = 4'd9,   // a + (b << sv)
    ALU_CMPEQ    = 4'd10
  } aluFnE;

  typedef struct packed {
    logic  regDst;    // result goes to rt
    logic  branch;
    logic  jump;
    logic  memRead;
    logic  memToReg;
    logic  memWrite;
    logic  aluSrc;    // operand b from immediate
    logic  regWrite;
    aluFnE aluFn;
  } ctrlT;

  typedef struct packed {
    logic re;
    logic we;
    wordT addr;
    wordT wdata;
  } memReqT;

endpackage

//--- src/immGen.sv
`timescale 1ns/100ps

module immGen import isaPkg::*; (
  input  wordT   i_instr,
  input  immSelE i_immSel,
  output wordT   o_imm
);

  always_comb begin
    case (i_immSel)
      IMM5: begin
        o_imm = {27'b0, i_instr[RB_HI:RB_LO]};   // shift amount, unsigned
      end
      IMM15: begin
        o_imm = {{17{i_instr[14]}}, i_instr[14:0]};
      end
      IMM15ZE: begin
        o_imm = {17'b0, i_instr[14:0]};   // ori / xori
      end
      IMM20: begin
        o_imm = {{12{i_instr[19]}}, i_instr[19:0]};
      end
      IMM14: begin
        o_imm = {{18{i_instr[13]}}, i_instr[13:0]};   // beq halfword offset
      end
      IMM24: begin
        o_imm = {{8{i_instr[23]}}, i_instr[23:0]};   // j halfword offset
      end
      default: begin
        o_imm = '0;
      end
    endcase
  end

endmodule

//--- src/isaPkg.sv
package isaPkg;

  typedef logic [31:0] wordT;    // data and address word
  typedef logic [4:0]  regAddrT;

  // instruction field positions
  localparam int unsigned OPC_HI = 30;
  localparam int unsigned OPC_LO = 25;
  localparam int unsigned RT_HI  = 24;
  localparam int unsigned RT_LO  = 20;
  localparam int unsigned RA_HI  = 19;
  localparam int unsigned RA_LO  = 15;
  localparam int unsigned RB_HI  = 14;
  localparam int unsigned RB_LO  = 10;
  localparam int unsigned SV_HI  = 9;
  localparam int unsigned SV_LO  = 8;
  localparam int unsigned SUB_HI = 4;
  localparam int unsigned SUB_LO = 0;

  typedef enum logic [5:0] {
    OP_LWI  = 6'b000010,
    OP_SWI  = 6'b001010,
    OP_MEM  = 6'b011100,  // LW / SW by sub-opcode
    OP_ALU  = 6'b100000,  // register ALU and immediate shifts
    OP_MOVI = 6'b100010,
    OP_J    = 6'b100100,
    OP_BEQ  = 6'b100110,
    OP_ADDI = 6'b101000,
    OP_XORI = 6'b101011,
    OP_ORI  = 6'b101100
  } opcodeE;

  typedef enum logic [4:0] {
    SUB_ADD   = 5'b00000,
    SUB_SUB   = 5'b00001,
    SUB_AND   = 5'b00010,
    SUB_XOR   = 5'b00011,
    SUB_OR    = 5'b00100,
    SUB_SLLI  = 5'b01000,
    SUB_SRLI  = 5'b01001,
    SUB_SW    = 5'b01010,
    SUB_ROTRI = 5'b01011
  } subOpE;

  localparam subOpE SUB_LW = SUB_AND;  // same code, only under OP_MEM

  typedef enum logic [2:0] {
    IMM0    = 3'b000,
    IMM5    = 3'b001,  // shift amount in rb field
    IMM15   = 3'b010,
    IMM20   = 3'b011,
    IMM14   = 3'b100,
    IMM24   = 3'b101,
    IMM15ZE = 3'b110
  } immSelE;

endpackage

//--- src/pcUnit.sv
`timescale 1ns/100ps

module pcUnit import isaPkg::*; #(
  parameter wordT RESET_PC = 32'h0000_0000
) (
  input  logic i_clk,
  input  logic i_rstN,
  input  logic i_branch,
  input  logic i_jump,
  input  logic i_equal,
  input  wordT i_imm,
  output wordT o_pc
);

  logic taken;
  wordT nextPc;

  assign taken  = i_jump || (i_branch && i_equal);
  assign nextPc = taken ? o_pc + {i_imm[30:0], 1'b0}   // offsets count halfwords
                        : o_pc + 32'd4;

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_pc <= RESET_PC;
    end else begin
      o_pc <= nextPc;
    end
  end

endmodule

//--- src/regFile.sv
`timescale 1ns/100ps

module regFile import isaPkg::*; (
  input  logic    i_clk,
  input  logic    i_rstN,
  input  regAddrT i_raddrA,
  input  regAddrT i_raddrB,
  input  regAddrT i_waddr,
  input  logic    i_we,
  input  wordT    i_wdata,
  output wordT    o_rdataA,
  output wordT    o_rdataB
);

  wordT regs [32];

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_waddr] <= i_wdata;   // r0 is an ordinary register here
    end
  end

  // no bypass, a write shows up next cycle
  assign o_rdataA = regs[i_raddrA];
  assign o_rdataB = regs[i_raddrB];

endmodule

//--- verif/tbCpuCore.sv
`timescale 1ns/100ps

module tbCpuCore
  import isaPkg::*;
  import ctrlPkg::*;
();

  localparam wordT RESET_PC     = 32'h0000_0000;
  localparam int   RESET_CYCLES = 4;
  localparam int   N_SETUP      = 5;
  localparam int   N_RANDOM     = 300;
  localparam int   N_SWEEP      = 32;
  localparam int   N_INSTR      = 1 + N_SETUP + N_RANDOM + N_SWEEP + 1;  // idle word at both ends
  localparam int   TIMEOUT      = N_INSTR + RESET_CYCLES + 20;
  localparam int   MEM_WORDS    = 512;   // byte addresses 0 .. 0x7fc

  logic   clk;
  logic   rstN;
  wordT   instr;
  wordT   memRdata;
  wordT   pc;
  memReqT memReq;

  wordT   dataMem   [MEM_WORDS];   // memory behind the dut
  wordT   shadowMem [MEM_WORDS];
  wordT   shadowReg [32];
  wordT   shadowPc;

  integer seed        = 96908;
  int     pcErrors    = 0;
  int     reqErrors   = 0;
  int     otherErrors = 0;
  int     storesSeen  = 0;
  int     cycles      = 0;

  cpuCore #(
    .RESET_PC(RESET_PC)
  ) UUT (
    .i_clk     (clk),
    .i_rstN    (rstN),
    .i_instr   (instr),
    .i_memRdata(memRdata),
    .o_pc      (pc),
    .o_memReq  (memReq)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  assign memRdata = memReq.re ? dataMem[memReq.addr[10:2]] : '0;   // same-cycle load

  function automatic wordT fillWord(input int idx);
    return (wordT'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic wordT encR(input logic [5:0] opc, input regAddrT rt, input regAddrT ra,
                                input regAddrT rb, input logic [1:0] sv, input logic [4:0] sub);
    return {1'b0, opc, rt, ra, rb, sv, 3'b000, sub};
  endfunction

  function automatic wordT encI15(input logic [5:0] opc, input regAddrT rt, input regAddrT ra,
                                  input logic [14:0] imm);
    return {1'b0, opc, rt, ra, imm};
  endfunction

  function automatic wordT encMovi(input regAddrT rt, input logic [19:0] imm);
    return {1'b0, OP_MOVI, rt, imm};
  endfunction

  function automatic wordT encBeq(input regAddrT rt, input regAddrT ra, input logic [13:0] imm);
    return {1'b0, OP_BEQ, rt, ra, 1'b0, imm};
  endfunction

  function automatic logic isDefinedOpc(input logic [5:0] opc);
    case (opc)
      OP_ALU, OP_ADDI, OP_ORI, OP_XORI, OP_LWI, OP_SWI, OP_MOVI, OP_MEM, OP_BEQ, OP_J: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // r1..r3 hold bases, r4..r5 scaled indexes, only r6..r31 are destinations
  function automatic regAddrT dstReg();
    return regAddrT'(6 + pick(26));
  endfunction

  function automatic logic [14:0] memOff();
    int off;
    off = 4 * pick(256) - 512;   // keeps base + offset word aligned and in range
    return off[14:0];
  endfunction

  function automatic wordT randomInstr();
    wordT       rnd;
    logic [4:0] sub;
    logic [5:0] opc;
    regAddrT    r;
    rnd = $random(seed);
    case (pick(16))
      0, 1: begin
        case (pick(5))
          0: sub = SUB_ADD;
          1: sub = SUB_SUB;
          2: sub = SUB_AND;
          3: sub = SUB_OR;
          default: sub = SUB_XOR;
        endcase
        return encR(OP_ALU, dstReg(), regAddrT'(pick(32)), regAddrT'(pick(32)), rnd[9:8], sub);
      end
      2: begin
        sub = (pick(3) == 0) ? SUB_SLLI : (pick(2) == 0) ? SUB_SRLI : SUB_ROTRI;
        return encR(OP_ALU, dstReg(), regAddrT'(pick(32)), rnd[14:10], 2'b00, sub);
      end
      3: return encI15(OP_ADDI, dstReg(), regAddrT'(pick(32)), rnd[14:0]);
      4: begin
        opc = pick(2) ? OP_ORI : OP_XORI;
        return encI15(opc, dstReg(), regAddrT'(pick(32)), rnd[14:0]);
      end
      5: return encMovi(dstReg(), rnd[19:0]);
      6: return encI15(OP_LWI, dstReg(), regAddrT'(1 + pick(3)), memOff());
      7, 15: return encI15(OP_SWI, regAddrT'(pick(32)), regAddrT'(1 + pick(3)), memOff());
      8: return encR(OP_MEM, dstReg(), regAddrT'(1 + pick(3)), regAddrT'(4 + pick(2)),
                     rnd[1:0], SUB_LW);
      9: return encR(OP_MEM, regAddrT'(pick(32)), regAddrT'(1 + pick(3)),
                     regAddrT'(4 + pick(2)), rnd[1:0], SUB_SW);
      10: begin
        r = regAddrT'(pick(32));
        return encBeq(r, r, rnd[13:0]);   // always taken
      end
      11: return encBeq(regAddrT'(pick(32)), regAddrT'(pick(32)), rnd[13:0]);
      12: return {1'b0, OP_J, 1'b0, rnd[23:0]};
      13: begin
        do begin
          opc = pick(64);
        end while (isDefinedOpc(opc));
        return {1'b0, opc, rnd[24:0]};
      end
      default: begin
        sub = 16 + pick(16);   // upper half is free under both opcodes
        opc = pick(2) ? OP_ALU : OP_MEM;
        return {1'b0, opc, rnd[24:5], sub};
      end
    endcase
  endfunction

  // applies one instruction to the shadow state, returns expected request and next pc
  function automatic void refStep(input wordT ins, output memReqT req, output wordT nextPc);
    regAddrT rt;
    regAddrT ra;
    regAddrT rb;
    wordT    a;
    wordT    b;
    wordT    t;
    wordT    s15;
    wordT    z15;
    wordT    val;
    logic    wr;
    rt     = ins[24:20];
    ra     = ins[19:15];
    rb     = ins[14:10];
    a      = shadowReg[ra];
    b      = shadowReg[rb];
    t      = shadowReg[rt];
    s15    = {{17{ins[14]}}, ins[14:0]};
    z15    = {17'b0, ins[14:0]};
    req    = '0;
    nextPc = shadowPc + 32'd4;
    wr     = 1'b0;
    val    = '0;
    case (ins[30:25])
      OP_ALU: begin
        wr = 1'b1;
        case (ins[4:0])
          SUB_ADD:   val = a + b;
          SUB_SUB:   val = a - b;
          SUB_AND:   val = a & b;
          SUB_OR:    val = a | b;
          SUB_XOR:   val = a ^ b;
          SUB_SLLI:  val = a << rb;
          SUB_SRLI:  val = a >> rb;
          SUB_ROTRI: val = (a >> rb) | (a << (32 - rb));
          default:   wr = 1'b0;
        endcase
      end
      OP_ADDI: {wr, val} = {1'b1, a + s15};
      OP_ORI:  {wr, val} = {1'b1, a | z15};
      OP_XORI: {wr, val} = {1'b1, a ^ z15};
      OP_MOVI: {wr, val} = {1'b1, {{12{ins[19]}}, ins[19:0]}};
      OP_LWI, OP_SWI, OP_MEM: begin
        req.addr = (ins[30:25] == OP_MEM) ? a + (b << ins[9:8]) : a + s15;
        req.re   = (ins[30:25] == OP_LWI) || (ins[30:25] == OP_MEM && ins[4:0] == SUB_LW);
        req.we   = (ins[30:25] == OP_SWI) || (ins[30:25] == OP_MEM && ins[4:0] == SUB_SW);
        wr       = req.re;
        val      = shadowMem[req.addr[10:2]];
        if (req.we) begin
          req.wdata                  = t;
          shadowMem[req.addr[10:2]] = t;
        end
      end
      OP_BEQ: if (a == t) nextPc = shadowPc + ({{18{ins[13]}}, ins[13:0]} << 1);
      OP_J:   nextPc = shadowPc + ({{8{ins[23]}}, ins[23:0]} << 1);
      default: ;
    endcase
    if (wr) shadowReg[rt] = val;
  endfunction

  task automatic checkPc(input wordT exp, input wordT act);
    if (act !== exp) begin
      pcErrors++;
      $display("[FAIL] o_pc expected %h got %h", exp, act);
    end
  endtask

  task automatic checkMemReq(input memReqT exp, input memReqT act);
    if (act.re !== exp.re || act.we !== exp.we) begin
      reqErrors++;
      $display("[FAIL] o_memReq.re/we expected %h/%h got %h/%h", exp.re, exp.we, act.re, act.we);
    end else if ((exp.re || exp.we) && act.addr !== exp.addr) begin
      reqErrors++;
      $display("[FAIL] o_memReq.addr expected %h got %h", exp.addr, act.addr);
    end else if (exp.we && act.wdata !== exp.wdata) begin
      reqErrors++;
      $display("[FAIL] o_memReq.wdata expected %h got %h", exp.wdata, act.wdata);
    end
  endtask

  task automatic issue(input wordT ins);
    @(negedge clk);
    instr = ins;
  endtask

  always @(posedge clk) begin : compare
    memReqT expReq;
    wordT   nextPc;
    if (rstN) begin
      checkPc(shadowPc, pc);
      refStep(instr, expReq, nextPc);
      checkMemReq(expReq, memReq);
      if ((memReq.re || memReq.we) && (memReq.addr[1:0] != 2'b00 || memReq.addr >= 32'h800)) begin
        otherErrors++;
        $display("data access at %h falls outside the modeled memory", memReq.addr);
      end
      shadowPc = nextPc;
    end
  end

  always @(posedge clk) begin
    if (rstN && memReq.we) begin
      dataMem[memReq.addr[10:2]] <= memReq.wdata;
      storesSeen++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("run still busy after %0d cycles, stopping", TIMEOUT);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin : stimulus
    wordT val;
    rstN     = 1'b0;
    instr    = '0;   // zero word is a nop
    shadowPc = RESET_PC;
    for (int i = 0; i < MEM_WORDS; i++) begin
      dataMem[i]   = fillWord(i);
      shadowMem[i] = fillWord(i);
    end
    for (int r = 0; r < 32; r++) begin
      shadowReg[r] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rstN = 1'b1;   // first cycle out of reset still sees the zero word
    for (int r = 1; r <= 3; r++) begin
      val = 32'h200 + 4 * pick(256);
      issue(encMovi(regAddrT'(r), val[19:0]));
    end
    for (int r = 4; r <= 5; r++) begin
      val = 4 * pick(16);
      issue(encMovi(regAddrT'(r), val[19:0]));
    end
    repeat (N_RANDOM) issue(randomInstr());
    for (int r = 0; r < 32; r++) begin
      val = 4 * r;   // dump every register through store data
      issue(encI15(OP_SWI, regAddrT'(r), 5'd1, val[14:0]));
    end
    issue('0);
    @(posedge clk);
    #1;
    if (storesSeen == 0) begin
      otherErrors++;
      $display("no store reached the data memory during the run");
    end
    $display("errors: pc %0d, memReq %0d, other %0d (stores %0d)",
             pcErrors, reqErrors, otherErrors, storesSeen);
    if (pcErrors + reqErrors + otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
